// ==== all.f ====
design/isa_pkg.sv
design/uop_pkg.sv
design/base_decoder.sv
design/muldiv_decoder.sv
design/decode_merge.sv
design/inst_decoder.sv
testbench/tb_inst_decoder.sv

// ==== design/base_decoder.sv ====
`timescale 1ns/1ps

module base_decoder import isa_pkg::*, uop_pkg::*; (
	input	logic	[XLEN-1:0]	inst,
	output	logic				base_hit,
	output	logic	[XLEN-1:0]	immediate,
	output	logic				rs1_access,
	output	logic				rs2_access,
	output	logic				rd_access,
	output	logic				sel_pc,
	output	logic				sel_imm,
	output	alu_op_e			alu_op,
	output	mem_op_e			mem_op,
	output	logic				dmem_access,
	output	logic				jump_ena,
	output	logic				jump_ind
);

	opcode_e			opcode;
	logic	[2:0]		funct3;
	logic	[6:0]		funct7;
	logic	[XLEN-1:0]	imm_i;
	logic	[XLEN-1:0]	imm_s;
	logic	[XLEN-1:0]	imm_b;
	logic	[XLEN-1:0]	imm_u;
	logic	[XLEN-1:0]	imm_j;
	logic				is_reg;
	logic				alt_ok;
	logic				funct7_free;
	logic				arith_ok;
	alu_op_e			arith_op;

	assign opcode	= opcode_e'(inst[6:0]);
	assign funct3	= inst[14:12];
	assign funct7	= inst[31:25];
	assign is_reg	= (opcode == OP_REG);

	assign imm_i	= {{21{inst[31]}}, inst[30:20]};
	assign imm_s	= {{21{inst[31]}}, inst[30:25], inst[11:7]};
	assign imm_b	= {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u	= {inst[31:12], 12'h000};
	assign imm_j	= {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	// funct3 map shared by the register and immediate forms
	always_comb begin
		arith_op	= ALU_ADD;
		alt_ok		= 1'b0;
		case (funct3)
			3'b000: begin
				arith_op	= (is_reg && funct7 == FUNCT7_ALT) ? ALU_SUB : ALU_ADD;
				alt_ok		= is_reg;
			end
			3'b001:	arith_op = ALU_SLL;
			3'b010:	arith_op = ALU_SLT;
			3'b011:	arith_op = ALU_SLTU;
			3'b100:	arith_op = ALU_XOR;
			3'b101: begin
				arith_op	= (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
				alt_ok		= 1'b1;
			end
			3'b110:	arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
		// immediate forms other than shifts carry imm bits in funct7
		funct7_free	= !is_reg && funct3 != 3'b001 && funct3 != 3'b101;
		arith_ok	= funct7_free || funct7 == FUNCT7_BASE || (alt_ok && funct7 == FUNCT7_ALT);
	end

	always_comb begin
		base_hit	= 1'b0;
		immediate	= '0;
		rs1_access	= 1'b0;
		rs2_access	= 1'b0;
		rd_access	= 1'b0;
		sel_pc		= 1'b0;
		sel_imm		= 1'b0;
		alu_op		= ALU_ADD;
		mem_op		= MEM_NONE;
		dmem_access	= 1'b0;
		jump_ena	= 1'b0;
		jump_ind	= 1'b0;

		case (opcode)
			OP_LUI, OP_AUIPC: begin
				base_hit	= 1'b1;
				immediate	= imm_u;
				rd_access	= 1'b1;
				sel_imm		= 1'b1;
				sel_pc		= (opcode == OP_AUIPC);
			end
			OP_JAL: begin
				base_hit	= 1'b1;
				immediate	= imm_j;
				rd_access	= 1'b1;
				sel_pc		= 1'b1;
				alu_op		= ALU_INC;
				jump_ena	= 1'b1;
			end
			OP_JALR: begin
				if (funct3 == 3'b000) begin
					base_hit	= 1'b1;
					immediate	= imm_i;
					rs1_access	= 1'b1;
					rd_access	= 1'b1;
					sel_pc		= 1'b1;
					alu_op		= ALU_INC;
					jump_ena	= 1'b1;
					jump_ind	= 1'b1;
				end
			end
			OP_BRANCH: begin
				// funct3 010 and 011 are unused
				if (funct3[2:1] != 2'b01) begin
					base_hit	= 1'b1;
					immediate	= imm_b;
					rs1_access	= 1'b1;
					rs2_access	= 1'b1;
					jump_ena	= 1'b1;
					case (funct3)
						3'b000:	alu_op = ALU_SEQ;
						3'b001:	alu_op = ALU_SNE;
						3'b100:	alu_op = ALU_SLT;
						3'b101:	alu_op = ALU_SGE;
						3'b110:	alu_op = ALU_SLTU;
						default: alu_op = ALU_SGEU;
					endcase
				end
			end
			OP_LOAD: begin
				case (funct3)
					3'b000:	mem_op = MEM_LB;
					3'b001:	mem_op = MEM_LH;
					3'b010:	mem_op = MEM_LW;
					3'b100:	mem_op = MEM_LBU;
					3'b101:	mem_op = MEM_LHU;
					default: mem_op = MEM_NONE;
				endcase
				base_hit	= (mem_op != MEM_NONE);
				immediate	= base_hit ? imm_i : '0;
				rs1_access	= base_hit;
				rd_access	= base_hit;
				sel_imm		= base_hit;
				dmem_access	= base_hit;
			end
			OP_STORE: begin
				case (funct3)
					3'b000:	mem_op = MEM_SB;
					3'b001:	mem_op = MEM_SH;
					3'b010:	mem_op = MEM_SW;
					default: mem_op = MEM_NONE;
				endcase
				base_hit	= (mem_op != MEM_NONE);
				immediate	= base_hit ? imm_s : '0;
				rs1_access	= base_hit;
				rs2_access	= base_hit;
				sel_imm		= base_hit;
				dmem_access	= base_hit;
			end
			OP_IMM, OP_REG: begin
				if (arith_ok) begin
					base_hit	= 1'b1;
					immediate	= is_reg ? '0 : imm_i;
					rs1_access	= 1'b1;
					rs2_access	= is_reg;
					rd_access	= 1'b1;
					sel_imm		= !is_reg;
					alu_op		= arith_op;
				end
			end
			// fence and the two system words drive no controls
			OP_MISC_MEM:	base_hit = (funct3 == 3'b000);
			OP_SYSTEM:		base_hit = (inst == INST_ECALL) || (inst == INST_EBREAK);
			default: ;
		endcase
	end

endmodule

// ==== design/decode_merge.sv ====
`timescale 1ns/1ps

module decode_merge import isa_pkg::*, uop_pkg::*; (
	input	logic					clk,
	input	logic					reset,
	input	logic					inst_valid,
	input	logic	[XLEN-1:0]		inst,
	input	logic					base_hit,
	input	logic	[XLEN-1:0]		base_immediate,
	input	logic					base_rs1_access,
	input	logic					base_rs2_access,
	input	logic					base_rd_access,
	input	logic					base_sel_pc,
	input	logic					base_sel_imm,
	input	alu_op_e				base_alu_op,
	input	mem_op_e				base_mem_op,
	input	logic					base_dmem_access,
	input	logic					base_jump_ena,
	input	logic					base_jump_ind,
	input	logic					md_hit,
	input	logic					md_is_div,
	input	mul_op_e				md_mul_op,
	input	div_op_e				md_div_op,
	output	logic					dec_valid,
	output	logic	[XLEN-1:0]		immediate,
	output	logic	[REG_ADDR_W-1:0]	rs1_addr,
	output	logic					rs1_access,
	output	logic	[REG_ADDR_W-1:0]	rs2_addr,
	output	logic					rs2_access,
	output	logic	[REG_ADDR_W-1:0]	rd_addr,
	output	logic					rd_access,
	output	logic					sel_pc,
	output	logic					sel_imm,
	output	logic					sel_mul,
	output	logic					sel_div,
	output	mem_op_e				mem_op,
	output	alu_op_e				alu_op,
	output	mul_op_e				mul_op,
	output	div_op_e				div_op,
	output	logic					dmem_access,
	output	logic					jump_ena,
	output	logic					jump_ind,
	output	logic					illegal_inst
);

	// idle first, a taken word overrides below
	always_ff @(posedge clk) begin
		dec_valid		<= 1'b0;
		immediate		<= '0;
		rs1_addr		<= '0;
		rs1_access		<= 1'b0;
		rs2_addr		<= '0;
		rs2_access		<= 1'b0;
		rd_addr			<= '0;
		rd_access		<= 1'b0;
		sel_pc			<= 1'b0;
		sel_imm			<= 1'b0;
		sel_mul			<= 1'b0;
		sel_div			<= 1'b0;
		mem_op			<= MEM_NONE;
		alu_op			<= ALU_ADD;
		mul_op			<= UMULL;
		div_op			<= SDIV;
		dmem_access		<= 1'b0;
		jump_ena		<= 1'b0;
		jump_ind		<= 1'b0;
		illegal_inst	<= 1'b0;

		if (!reset && inst_valid) begin
			dec_valid		<= 1'b1;
			rs1_addr		<= inst[19:15];
			rs2_addr		<= inst[24:20];
			rd_addr			<= inst[11:7];
			illegal_inst	<= !base_hit && !md_hit;
			// the decoders claim disjoint words, at most one hit is set
			if (base_hit) begin
				immediate	<= base_immediate;
				rs1_access	<= base_rs1_access;
				rs2_access	<= base_rs2_access;
				rd_access	<= base_rd_access;
				sel_pc		<= base_sel_pc;
				sel_imm		<= base_sel_imm;
				alu_op		<= base_alu_op;
				mem_op		<= base_mem_op;
				dmem_access	<= base_dmem_access;
				jump_ena	<= base_jump_ena;
				jump_ind	<= base_jump_ind;
			end
			if (md_hit) begin
				rs1_access	<= 1'b1;
				rs2_access	<= 1'b1;
				rd_access	<= 1'b1;
				sel_mul		<= !md_is_div;
				sel_div		<= md_is_div;
				mul_op		<= md_mul_op;
				div_op		<= md_div_op;
			end
		end
	end

endmodule

// ==== design/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder import isa_pkg::*, uop_pkg::*; (
	input	logic					clk,
	input	logic					reset,
	input	logic					inst_valid,
	input	logic	[XLEN-1:0]		inst,
	output	logic					dec_valid,
	output	logic	[XLEN-1:0]		immediate,
	output	logic	[REG_ADDR_W-1:0]	rs1_addr,
	output	logic					rs1_access,
	output	logic	[REG_ADDR_W-1:0]	rs2_addr,
	output	logic					rs2_access,
	output	logic	[REG_ADDR_W-1:0]	rd_addr,
	output	logic					rd_access,
	output	logic					sel_pc,
	output	logic					sel_imm,
	output	logic					sel_mul,
	output	logic					sel_div,
	output	mem_op_e				mem_op,
	output	alu_op_e				alu_op,
	output	mul_op_e				mul_op,
	output	div_op_e				div_op,
	output	logic					dmem_access,
	output	logic					jump_ena,
	output	logic					jump_ind,
	output	logic					illegal_inst
);

	logic				base_hit;
	logic	[XLEN-1:0]	base_immediate;
	logic				base_rs1_access;
	logic				base_rs2_access;
	logic				base_rd_access;
	logic				base_sel_pc;
	logic				base_sel_imm;
	alu_op_e			base_alu_op;
	mem_op_e			base_mem_op;
	logic				base_dmem_access;
	logic				base_jump_ena;
	logic				base_jump_ind;
	logic				md_hit;
	logic				md_is_div;
	mul_op_e			md_mul_op;
	div_op_e			md_div_op;

	base_decoder i_base_decoder (
		.inst			(inst),
		.base_hit		(base_hit),
		.immediate		(base_immediate),
		.rs1_access		(base_rs1_access),
		.rs2_access		(base_rs2_access),
		.rd_access		(base_rd_access),
		.sel_pc			(base_sel_pc),
		.sel_imm		(base_sel_imm),
		.alu_op			(base_alu_op),
		.mem_op			(base_mem_op),
		.dmem_access	(base_dmem_access),
		.jump_ena		(base_jump_ena),
		.jump_ind		(base_jump_ind)
	);

	muldiv_decoder i_muldiv_decoder (
		.inst			(inst),
		.md_hit			(md_hit),
		.md_is_div		(md_is_div),
		.mul_op			(md_mul_op),
		.div_op			(md_div_op)
	);

	// port names match the local nets one for one
	decode_merge i_decode_merge (.*);

endmodule

// ==== design/isa_pkg.sv ====
package isa_pkg;

	localparam int XLEN			= 32;
	localparam int REG_ADDR_W	= 5;

	// major opcodes, taken from inst[6:0]
	typedef enum logic [6:0] {
		OP_LOAD		= 7'b0000011,
		OP_MISC_MEM	= 7'b0001111,
		OP_IMM		= 7'b0010011,
		OP_AUIPC	= 7'b0010111,
		OP_STORE	= 7'b0100011,
		OP_REG		= 7'b0110011,
		OP_LUI		= 7'b0110111,
		OP_BRANCH	= 7'b1100011,
		OP_JALR		= 7'b1100111,
		OP_JAL		= 7'b1101111,
		OP_SYSTEM	= 7'b1110011
	} opcode_e;

	// funct7 markers for OP_REG and the shift immediates
	localparam logic [6:0] FUNCT7_BASE		= 7'b0000000;
	localparam logic [6:0] FUNCT7_ALT		= 7'b0100000;
	localparam logic [6:0] FUNCT7_MULDIV	= 7'b0000001;

	// only these two SYSTEM words are legal
	localparam logic [XLEN-1:0] INST_ECALL	= 32'h00000073;
	localparam logic [XLEN-1:0] INST_EBREAK	= 32'h00100073;

endpackage

// ==== design/muldiv_decoder.sv ====
`timescale 1ns/1ps

module muldiv_decoder import isa_pkg::*, uop_pkg::*; (
	input	logic	[XLEN-1:0]	inst,
	output	logic				md_hit,
	output	logic				md_is_div,
	output	mul_op_e			mul_op,
	output	div_op_e			div_op
);

	logic	[2:0]	funct3;

	assign funct3		= inst[14:12];
	// M words sit in OP_REG and differ from the base set only in funct7
	assign md_hit		= (inst[6:0] == OP_REG) && (inst[31:25] == FUNCT7_MULDIV);
	assign md_is_div	= md_hit && funct3[2];

	always_comb begin
		mul_op	= UMULL;
		div_op	= SDIV;
		if (md_hit) begin
			case (funct3)
				// plain mul only needs the low word
				3'b000:	mul_op = UMULL;
				3'b001:	mul_op = SMULH;
				3'b010:	mul_op = SUMULH;
				3'b011:	mul_op = UMULH;
				3'b100:	div_op = SDIV;
				3'b101:	div_op = UDIV;
				3'b110:	div_op = SREM;
				default: div_op = UREM;
			endcase
		end
	end

endmodule

// ==== design/uop_pkg.sv ====
package uop_pkg;

	// ALU_ADD doubles as the idle value
	typedef enum logic [3:0] {
		ALU_ADD		= 4'd0,
		ALU_SUB,
		ALU_INC,
		ALU_SEQ,
		ALU_SNE,
		ALU_SLT,
		ALU_SGE,
		ALU_SLTU,
		ALU_SGEU,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_e;

	typedef enum logic [3:0] {
		MEM_NONE	= 4'd0,
		MEM_LB,
		MEM_LH,
		MEM_LW,
		MEM_LBU,
		MEM_LHU,
		MEM_SB,
		MEM_SH,
		MEM_SW
	} mem_op_e;

	typedef enum logic [1:0] {
		UMULL		= 2'd0,
		SMULH,
		SUMULH,
		UMULH
	} mul_op_e;

	typedef enum logic [1:0] {
		SDIV		= 2'd0,
		UDIV,
		SREM,
		UREM
	} div_op_e;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" && \
	verilator --binary -f all.f --top-module tb_inst_decoder -o tb_inst_decoder && \
	./obj_dir/tb_inst_decoder || exit 1

// ==== testbench/decoder_vectors.txt ====
// inst imm flags alu mem mul div illegal, one hex digit per flag:
// rs1_access rs2_access rd_access sel_pc sel_imm sel_mul sel_div dmem_access jump_ena jump_ind
002081B3 00000000 1110000000 0 0 0 0 0
402081B3 00000000 1110000000 1 0 0 0 0
002091B3 00000000 1110000000 C 0 0 0 0
0020A1B3 00000000 1110000000 5 0 0 0 0
0020B1B3 00000000 1110000000 7 0 0 0 0
0020C1B3 00000000 1110000000 9 0 0 0 0
0020D1B3 00000000 1110000000 D 0 0 0 0
4020D1B3 00000000 1110000000 E 0 0 0 0
0020E1B3 00000000 1110000000 A 0 0 0 0
0020F1B3 00000000 1110000000 B 0 0 0 0
FFF08193 FFFFFFFF 1010100000 0 0 0 0 0
8000B193 FFFFF800 1010100000 7 0 0 0 0
7FF0C193 000007FF 1010100000 9 0 0 0 0
FF00F193 FFFFFFF0 1010100000 B 0 0 0 0
00509193 00000005 1010100000 C 0 0 0 0
4030D193 00000403 1010100000 E 0 0 0 0
FFC10283 FFFFFFFC 1010100100 0 1 0 0 0
00811283 00000008 1010100100 0 2 0 0 0
7FC12283 000007FC 1010100100 0 3 0 0 0
00014283 00000000 1010100100 0 4 0 0 0
FFE15283 FFFFFFFE 1010100100 0 5 0 0 0
006100A3 00000001 1100100100 0 6 0 0 0
FE611C23 FFFFFFF8 1100100100 0 7 0 0 0
12612223 00000124 1100100100 0 8 0 0 0
00208863 00000010 1100000010 3 0 0 0 0
FE209EE3 FFFFFFFC 1100000010 4 0 0 0 0
0020C0E3 00000800 1100000010 5 0 0 0 0
7E20DF63 000007FE 1100000010 6 0 0 0 0
0220E063 00000020 1100000010 7 0 0 0 0
8020F063 FFFFF000 1100000010 8 0 0 0 0
005000EF 00000804 0011000010 2 0 0 0 0
8000006F FFF00000 0011000010 2 0 0 0 0
00C280E7 0000000C 1011000011 2 0 0 0 0
ABCDE3B7 ABCDE000 0010100000 0 0 0 0 0
00010397 00010000 0011100000 0 0 0 0 0
020081B3 00000000 1110010000 0 0 0 0 0
020091B3 00000000 1110010000 0 0 1 0 0
0200A1B3 00000000 1110010000 0 0 2 0 0
0200B1B3 00000000 1110010000 0 0 3 0 0
0200C1B3 00000000 1110001000 0 0 0 0 0
0200D1B3 00000000 1110001000 0 0 0 1 0
0200E1B3 00000000 1110001000 0 0 0 2 0
0200F1B3 00000000 1110001000 0 0 0 3 0
0FF0000F 00000000 0000000000 0 0 0 0 0
00000073 00000000 0000000000 0 0 0 0 0
00100073 00000000 0000000000 0 0 0 0 0
102081B3 00000000 0000000000 0 0 0 0 1
40509193 00000000 0000000000 0 0 0 0 1
00000000 00000000 0000000000 0 0 0 0 1
00012087 00000000 0000000000 0 0 0 0 1
002081D3 00000000 0000000000 0 0 0 0 1
00013283 00000000 0000000000 0 0 0 0 1
30001073 00000000 0000000000 0 0 0 0 1

// ==== testbench/tb_inst_decoder.sv ====
`timescale 1ns/1ps

module tb_inst_decoder import isa_pkg::*, uop_pkg::*; ();

	localparam int HALF_PERIOD		= 5;
	localparam int CLK_PERIOD		= 2 * HALF_PERIOD;
	localparam int NUM_VECTORS		= 53;
	localparam int VEC_FIELDS		= 8;
	localparam int NUM_RANDOM		= 40;
	// two passes over the table plus the random words
	localparam int WATCHDOG_CYCLES	= 20 * (2 * NUM_VECTORS + NUM_RANDOM) + 50;

	logic					clk			= 1'b0;
	logic					reset		= 1'b1;
	logic					inst_valid	= 1'b0;
	logic	[XLEN-1:0]		inst		= '0;
	logic					dec_valid;
	logic	[XLEN-1:0]		immediate;
	logic	[REG_ADDR_W-1:0]	rs1_addr;
	logic					rs1_access;
	logic	[REG_ADDR_W-1:0]	rs2_addr;
	logic					rs2_access;
	logic	[REG_ADDR_W-1:0]	rd_addr;
	logic					rd_access;
	logic					sel_pc;
	logic					sel_imm;
	logic					sel_mul;
	logic					sel_div;
	mem_op_e				mem_op;
	alu_op_e				alu_op;
	mul_op_e				mul_op;
	div_op_e				div_op;
	logic					dmem_access;
	logic					jump_ena;
	logic					jump_ind;
	logic					illegal_inst;

	logic	[39:0]			vec_mem [0:NUM_VECTORS*VEC_FIELDS-1];
	integer					seed;

	// expected result of the word driven one cycle earlier
	logic					prev_valid;
	logic	[XLEN-1:0]		prev_inst;
	logic	[XLEN-1:0]		prev_imm;
	logic	[9:0]			prev_flags;
	logic	[3:0]			prev_alu;
	logic	[3:0]			prev_mem;
	logic	[1:0]			prev_mul;
	logic	[1:0]			prev_div;
	logic					prev_ill;

	inst_decoder i_inst_decoder (.*);

	always #HALF_PERIOD clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0d ns: %s got %h, expected %h (inst %h)",
				$time, name, actual, expected, prev_inst);
			$display("Simulation failed");
			$fatal(1, "decode mismatch");
		end
	endtask

	// one hex digit per flag in the vector file with rs1_access leftmost
	function automatic logic [9:0] unpack_flags(input logic [39:0] digits);
		logic	[9:0]	flags;
		int				i;
		for (i = 0; i < 10; i++)
			flags[i] = digits[i*4];
		return flags;
	endfunction

	function automatic logic major_opcode(input logic [6:0] op);
		case (op)
			OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE,
			OP_IMM, OP_REG, OP_MISC_MEM, OP_SYSTEM: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	task automatic check_outputs;
		check_value("dec_valid", 32'(dec_valid), 32'(prev_valid));
		check_value("immediate", immediate, prev_imm);
		check_value("rs1_access", 32'(rs1_access), 32'(prev_flags[9]));
		check_value("rs2_access", 32'(rs2_access), 32'(prev_flags[8]));
		check_value("rd_access", 32'(rd_access), 32'(prev_flags[7]));
		check_value("sel_pc", 32'(sel_pc), 32'(prev_flags[6]));
		check_value("sel_imm", 32'(sel_imm), 32'(prev_flags[5]));
		check_value("sel_mul", 32'(sel_mul), 32'(prev_flags[4]));
		check_value("sel_div", 32'(sel_div), 32'(prev_flags[3]));
		check_value("dmem_access", 32'(dmem_access), 32'(prev_flags[2]));
		check_value("jump_ena", 32'(jump_ena), 32'(prev_flags[1]));
		check_value("jump_ind", 32'(jump_ind), 32'(prev_flags[0]));
		check_value("alu_op", 32'(alu_op), 32'(prev_alu));
		check_value("mem_op", 32'(mem_op), 32'(prev_mem));
		check_value("mul_op", 32'(mul_op), 32'(prev_mul));
		check_value("div_op", 32'(div_op), 32'(prev_div));
		check_value("illegal_inst", 32'(illegal_inst), 32'(prev_ill));
		// register fields come straight from the word even for illegal words
		check_value("rs1_addr", 32'(rs1_addr), 32'(prev_inst[19:15]));
		check_value("rs2_addr", 32'(rs2_addr), 32'(prev_inst[24:20]));
		check_value("rd_addr", 32'(rd_addr), 32'(prev_inst[11:7]));
	endtask

	// drive one cycle and check the result of the cycle before
	task automatic apply_step(input logic rst, input logic v, input logic [31:0] w,
			input logic [31:0] e_imm, input logic [9:0] e_flags, input logic [3:0] e_alu,
			input logic [3:0] e_mem, input logic [1:0] e_mul, input logic [1:0] e_div,
			input logic e_ill);
		@(posedge clk);
		reset		<= rst;
		inst_valid	<= v;
		inst		<= w;
		@(negedge clk);
		check_outputs();
		prev_valid	= v && !rst;
		prev_inst	= prev_valid ? w : '0;
		prev_imm	= prev_valid ? e_imm : '0;
		prev_flags	= prev_valid ? e_flags : '0;
		prev_alu	= prev_valid ? e_alu : '0;
		prev_mem	= prev_valid ? e_mem : '0;
		prev_mul	= prev_valid ? e_mul : '0;
		prev_div	= prev_valid ? e_div : '0;
		prev_ill	= prev_valid ? e_ill : 1'b0;
	endtask

	task automatic apply_vector(input int idx, input logic rst);
		int row;
		row = idx * VEC_FIELDS;
		apply_step(rst, 1'b1, vec_mem[row][31:0], vec_mem[row+1][31:0],
			unpack_flags(vec_mem[row+2]), vec_mem[row+3][3:0], vec_mem[row+4][3:0],
			vec_mem[row+5][1:0], vec_mem[row+6][1:0], vec_mem[row+7][0]);
	endtask

	task automatic apply_idle;
		apply_step(1'b0, 1'b0, '0, '0, '0, '0, '0, '0, '0, 1'b0);
	endtask

	task automatic apply_random_illegal;
		logic	[31:0]	w;
		w = $random(seed);
		while (major_opcode(w[6:0]))
			w = $random(seed);
		apply_step(1'b0, 1'b1, w, '0, '0, '0, '0, '0, '0, 1'b1);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the decoder test did not finish in %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		seed		= 32'h726e9502;
		prev_valid	= 1'b0;
		prev_inst	= '0;
		prev_imm	= '0;
		prev_flags	= '0;
		prev_alu	= '0;
		prev_mem	= '0;
		prev_mul	= '0;
		prev_div	= '0;
		prev_ill	= 1'b0;
		$readmemh("testbench/decoder_vectors.txt", vec_mem);
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		// back to back
		for (int i = 0; i < NUM_VECTORS; i++)
			apply_vector(i, 1'b0);

		// with gaps
		for (int i = 0; i < NUM_VECTORS; i++) begin
			apply_vector(i, 1'b0);
			if (i % 3 == 0)
				apply_idle();
		end

		for (int n = 0; n < NUM_RANDOM; n++)
			apply_random_illegal();

		// a word taken while reset is high gives no result
		apply_vector(0, 1'b1);
		apply_vector(1, 1'b0);
		apply_idle();

		$display("Simulation passed");
		$finish;
	end

endmodule
